// File: hw/hw_test_pkg.sv
package hw_test_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////
    localparam int OPERAND_W    = 16;
    localparam int RESULT_W     = 32;
    localparam int RESULT_BYTES = 4;

    // Opcodes, 4-bit field at the top of a vector
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_XOR = 4'h3,
        OP_MUL = 4'h4,
        OP_ILL = 4'hf   // Any code not listed above
    } op_e;

    localparam int VECTOR_W = $bits(op_e) + 2 * OPERAND_W;   // opcode | a | b

    ////////////////////
    // Sequencer states
    ////////////////////
    typedef enum logic [3:0] {
        S_INIT, S_CLR_ADDR, S_BEG_OP, S_CAPTURE,
        S_WAIT_READY, S_LOAD_BYTE, S_SEND, S_WAIT_TX,
        S_NEXT_CH, S_CHECK_ADDR, S_NEXT_ADDR, S_DONE
    } seq_state_e;

endpackage

// File: hw/uart_pkg.sv
package uart_pkg;

    ////////////////////
    // Frame format, 8N1
    ////////////////////
    localparam int UART_DATA_BITS  = 8;
    localparam int UART_FRAME_BITS = 10;   // start + data + stop

    // Transmitter FSM
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage

// File: hw/test_sequencer.sv
`timescale 1ns/100ps

module test_sequencer
    import hw_test_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ready_op,
    input  logic max_tick_address,
    input  logic max_tick_ch,
    input  logic tx_done,
    output logic beg_op,
    output logic ack_op,
    output logic load_address,
    output logic enab_address,
    output logic enab_ch,
    output logic load_ch,
    output logic tx_start,
    output logic done
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       frame_pending;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state_q <= S_INIT;
        else
            state_q <= state_d;
    end

    ////////////////////
    // Next state and strobes
    ////////////////////
    always_comb
    begin
        state_d      = state_q;
        beg_op       = 1'b0;
        ack_op       = 1'b0;
        load_address = 1'b0;
        enab_address = 1'b0;
        enab_ch      = 1'b0;
        load_ch      = 1'b0;
        tx_start     = 1'b0;
        done         = 1'b0;
        case (state_q)
            S_INIT:       state_d = S_CLR_ADDR;
            S_CLR_ADDR:
            begin
                load_address = 1'b1;   // Clear to vector 0
                enab_address = 1'b1;
                state_d      = S_BEG_OP;
            end
            S_BEG_OP:
            begin
                beg_op  = 1'b1;
                state_d = S_CAPTURE;
            end
            S_CAPTURE:
            begin
                beg_op  = 1'b1;
                load_ch = 1'b1;        // Vector capture, channel clear
                enab_ch = 1'b1;
                state_d = S_WAIT_READY;
            end
            S_WAIT_READY: if (ready_op) state_d = S_LOAD_BYTE;
            S_LOAD_BYTE:  state_d = S_SEND;
            S_SEND:
            begin
                tx_start = 1'b1;
                state_d  = S_WAIT_TX;
            end
            S_WAIT_TX:
            begin
                if (tx_done)
                    state_d = max_tick_ch ? S_CHECK_ADDR : S_NEXT_CH;
            end
            S_NEXT_CH:
            begin
                enab_ch = 1'b1;
                state_d = S_LOAD_BYTE;
            end
            S_CHECK_ADDR: state_d = max_tick_address ? S_DONE : S_NEXT_ADDR;
            S_NEXT_ADDR:
            begin
                enab_address = 1'b1;
                ack_op       = 1'b1;
                state_d      = S_BEG_OP;
            end
            S_DONE:       done = 1'b1;   // Parked until reset
            default:      state_d = S_INIT;
        endcase
    end

    // Frame in flight between tx_start and tx_done
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            frame_pending <= 1'b0;
        else if (tx_start)
            frame_pending <= 1'b1;
        else if (tx_done)
            frame_pending <= 1'b0;
    end

    a_no_overlap_frame: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !frame_pending);

endmodule

// File: hw/vector_decode.sv
`timescale 1ns/100ps

module vector_decode
    import hw_test_pkg::*;
#(
    parameter  int NUM_VECTORS = 8,
    localparam int ADDR_W      = (NUM_VECTORS > 1) ? $clog2(NUM_VECTORS) : 1
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_address,
    input  logic                 enab_address,
    input  logic                 load_ch,
    input  logic [VECTOR_W-1:0]  vec_data,
    output logic [ADDR_W-1:0]    vec_addr,
    output logic                 max_tick_address,
    output op_e                  opcode,
    output logic [OPERAND_W-1:0] operand_a,
    output logic [OPERAND_W-1:0] operand_b
);

    logic [VECTOR_W-1:0]     vector_q;
    logic [$bits(op_e)-1:0]  opcode_raw;

    ////////////////////
    // Address counter
    ////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            vec_addr <= '0;
        else if (enab_address)
            vec_addr <= load_address ? '0 : vec_addr + 1'b1;
    end

    assign max_tick_address = (vec_addr == ADDR_W'(NUM_VECTORS - 1));

    // Memory data is settled by the second beg_op cycle
    always_ff @(posedge clk)
    begin
        if (load_ch)
            vector_q <= vec_data;
    end

    ////////////////////
    // Field split
    ////////////////////
    assign opcode_raw = vector_q[VECTOR_W-1 -: $bits(op_e)];
    assign operand_a  = vector_q[2*OPERAND_W-1 -: OPERAND_W];
    assign operand_b  = vector_q[OPERAND_W-1:0];

    always_comb
    begin
        case (opcode_raw)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL: opcode = op_e'(opcode_raw);
            default:                                opcode = OP_ILL;
        endcase
    end

    // Sequencer must stop advancing at the last vector
    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        (enab_address && !load_address) |-> !max_tick_address);

endmodule

// File: hw/op_unit.sv
`timescale 1ns/100ps

module op_unit
    import hw_test_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 beg_op,
    input  logic                 ack_op,
    input  op_e                  opcode,
    input  logic [OPERAND_W-1:0] operand_a,
    input  logic [OPERAND_W-1:0] operand_b,
    output logic                 ready_op,
    output logic [RESULT_W-1:0]  result
);

    localparam int CNT_W = (OPERAND_W > 1) ? $clog2(OPERAND_W) : 1;

    logic                 armed;       // Waiting for the vector to settle
    logic                 mul_busy;
    logic [CNT_W-1:0]     mul_cnt;
    logic [RESULT_W-1:0]  mcand;
    logic [OPERAND_W-1:0] mplier;
    logic [RESULT_W-1:0]  alu_res;
    logic                 exec;

    assign exec = armed && !beg_op;   // First cycle after beg_op drops

    ////////////////////
    // Single cycle ops
    ////////////////////
    always_comb
    begin
        case (opcode)
            OP_ADD:  alu_res = RESULT_W'(operand_a) + RESULT_W'(operand_b);
            OP_SUB:  alu_res = RESULT_W'(operand_a) - RESULT_W'(operand_b);  // Wraps
            OP_AND:  alu_res = RESULT_W'(operand_a & operand_b);
            OP_XOR:  alu_res = RESULT_W'(operand_a ^ operand_b);
            default: alu_res = 32'hdead_beef;
        endcase
    end

    // Control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            armed    <= 1'b0;
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
            ready_op <= 1'b0;
        end
        else if (beg_op)
        begin
            armed    <= 1'b1;
            mul_busy <= 1'b0;
            ready_op <= 1'b0;
        end
        else if (exec)
        begin
            armed <= 1'b0;
            if (opcode == OP_MUL)
            begin
                mul_busy <= 1'b1;
                mul_cnt  <= '0;
            end
            else
                ready_op <= 1'b1;
        end
        else if (mul_busy)
        begin
            mul_cnt <= mul_cnt + 1'b1;
            if (mul_cnt == CNT_W'(OPERAND_W - 1))
            begin
                mul_busy <= 1'b0;
                ready_op <= 1'b1;
            end
        end
        else if (ack_op)
            ready_op <= 1'b0;
    end

    ////////////////////
    // Result and shift-and-add
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (exec)
        begin
            mcand  <= RESULT_W'(operand_a);
            mplier <= operand_b;
            result <= (opcode == OP_MUL) ? '0 : alu_res;
        end
        else if (mul_busy)
        begin
            if (mplier[0])
                result <= result + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

// File: hw/result_serializer.sv
`timescale 1ns/100ps

module result_serializer
    import hw_test_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_ch,
    input  logic                             enab_ch,
    input  logic [RESULT_W-1:0]              result,
    output logic [RESULT_W/RESULT_BYTES-1:0] tx_byte,
    output logic                             max_tick_ch
);

    localparam int BYTE_W = RESULT_W / RESULT_BYTES;
    localparam int CH_W   = (RESULT_BYTES > 1) ? $clog2(RESULT_BYTES) : 1;

    logic [CH_W-1:0] ch_cnt;

    // Channel counter, load has priority
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ch_cnt <= '0;
        else if (load_ch)
            ch_cnt <= '0;
        else if (enab_ch)
            ch_cnt <= ch_cnt + 1'b1;
    end

    assign tx_byte     = result[ch_cnt*BYTE_W +: BYTE_W];   // LSB first
    assign max_tick_ch = (ch_cnt == CH_W'(RESULT_BYTES - 1));

    // No step past the last byte
    a_ch_range: assert property (@(posedge clk) disable iff (rst)
        (enab_ch && !load_ch) |-> !max_tick_ch);

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tx_start,
    input  logic [UART_DATA_BITS-1:0] tx_byte,
    output logic                      tx,
    output logic                      tx_done
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BIT_W  = $clog2(UART_DATA_BITS);

    uart_state_e               state;
    logic [BAUD_W-1:0]         baud_cnt;
    logic [BIT_W-1:0]          bit_cnt;
    logic [UART_DATA_BITS-1:0] shift_q;
    logic                      baud_last;

    assign baud_last = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
    assign tx_done   = (state == STOP) && baud_last;   // Last cycle of stop bit

    ////////////////////
    // Frame FSM
    ////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end
        else
        begin
            baud_cnt <= (state == IDLE || baud_last) ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE:
                begin
                    if (tx_start)
                    begin
                        state <= START;
                        tx    <= 1'b0;
                    end
                end
                START:
                begin
                    if (baud_last)
                    begin
                        state   <= DATA;
                        bit_cnt <= '0;
                        tx      <= shift_q[0];
                    end
                end
                DATA:
                begin
                    if (baud_last)
                    begin
                        if (bit_cnt == BIT_W'(UART_DATA_BITS - 1))
                        begin
                            state <= STOP;
                            tx    <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_q[1];   // Next bit after the shift
                        end
                    end
                end
                STOP:    if (baud_last) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && tx_start)
            shift_q <= tx_byte;
        else if (state == DATA && baud_last)
            shift_q <= {1'b0, shift_q[UART_DATA_BITS-1:1]};
    end

endmodule

// File: hw/hw_test_top.sv
`timescale 1ns/100ps

module hw_test_top
    import hw_test_pkg::*;
#(
    parameter  int NUM_VECTORS  = 8,
    parameter  int CLKS_PER_BIT = 16,
    localparam int ADDR_W       = (NUM_VECTORS > 1) ? $clog2(NUM_VECTORS) : 1
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic [VECTOR_W-1:0] vec_data,
    output logic [ADDR_W-1:0]   vec_addr,
    output logic                tx,
    output logic                done
);

    logic                             beg_op;
    logic                             ack_op;
    logic                             load_address;
    logic                             enab_address;
    logic                             enab_ch;
    logic                             load_ch;
    logic                             tx_start;
    logic                             tx_done;
    logic                             ready_op;
    logic                             max_tick_address;
    logic                             max_tick_ch;
    op_e                              opcode;
    logic [OPERAND_W-1:0]             operand_a;
    logic [OPERAND_W-1:0]             operand_b;
    logic [RESULT_W-1:0]              result;
    logic [RESULT_W/RESULT_BYTES-1:0] tx_byte;

    ////////////////////
    // Control
    ////////////////////
    test_sequencer u_seq (
        .clk, .rst, .ready_op, .max_tick_address, .max_tick_ch, .tx_done,
        .beg_op, .ack_op, .load_address, .enab_address, .enab_ch, .load_ch,
        .tx_start, .done
    );

    ////////////////////
    // Datapath
    ////////////////////
    vector_decode #(.NUM_VECTORS(NUM_VECTORS)) u_decode (
        .clk, .rst, .load_address, .enab_address, .load_ch, .vec_data,
        .vec_addr, .max_tick_address, .opcode, .operand_a, .operand_b
    );

    op_unit u_op (
        .clk, .rst, .beg_op, .ack_op, .opcode, .operand_a, .operand_b,
        .ready_op, .result
    );

    result_serializer u_ser (
        .clk, .rst, .load_ch, .enab_ch, .result, .tx_byte, .max_tick_ch
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk, .rst, .tx_start, .tx_byte, .tx, .tx_done
    );

endmodule

// File: dv/hw_test_tb.sv
`timescale 1ns/100ps

module hw_test_tb
    import hw_test_pkg::*;
    import uart_pkg::*;
();

    localparam int NUM_VECTORS  = 8;
    localparam int CLKS_PER_BIT = 16;
    localparam int ADDR_W       = $clog2(NUM_VECTORS);
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_CYCLES = UART_FRAME_BITS * CLKS_PER_BIT;
    localparam int QUIET_CYCLES = 2 * FRAME_CYCLES;   // Idle watch after done
    localparam int WATCHDOG_NS  =
        NUM_VECTORS * RESULT_BYTES * FRAME_CYCLES * CLK_PERIOD * 2
        + NUM_VECTORS * (OPERAND_W + 1) * CLK_PERIOD
        + (RESET_CYCLES + QUIET_CYCLES) * CLK_PERIOD;

    // Fixed opcode column, operands come from the LFSR
    localparam logic [3:0] OP_CODES [NUM_VECTORS] = '{
        OP_ADD, OP_MUL, OP_SUB, OP_AND, OP_MUL, OP_XOR, 4'hb, OP_SUB
    };
    localparam op_e OPS_COUNTED [6] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL, OP_ILL};

    logic                clk;
    logic                rst;
    logic [VECTOR_W-1:0] vec_data;
    logic [ADDR_W-1:0]   vec_addr;
    logic                tx;
    logic                done;

    logic [VECTOR_W-1:0] vec_mem [NUM_VECTORS];
    logic [RESULT_W-1:0] exp_result [NUM_VECTORS];
    logic [31:0]         lfsr_state;
    int                  frame_cnt = 0;

    hw_test_top #(.NUM_VECTORS(NUM_VECTORS), .CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
        .clk, .rst, .vec_data, .vec_addr, .tx, .done
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign vec_data = vec_mem[vec_addr];   // Combinational vector memory

    ////////////////////
    // Error and checks
    ////////////////////
    task automatic raise_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            raise_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp)
            raise_error($sformatf("CHECK FAILED vec_addr: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            raise_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_result(input string name, input logic [RESULT_W-1:0] got,
                                input logic [RESULT_W-1:0] exp);
        if (got !== exp)
            raise_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_opcode_count(input op_e op, input int got, input int exp);
        if (got != exp)
            raise_error($sformatf("CHECK FAILED opcode count %s: got 0x%h expected 0x%h",
                                  op.name(), got, exp));
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_operand(output logic [OPERAND_W-1:0] val);
        val = '0;
        for (int i = 0; i < OPERAND_W; i++)
        begin
            val        = {val[OPERAND_W-2:0], lfsr_state[0]};   // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [RESULT_W-1:0] expected_result(input logic [3:0] code,
            input logic [OPERAND_W-1:0] a, input logic [OPERAND_W-1:0] b);
        logic [RESULT_W-1:0] wa;
        logic [RESULT_W-1:0] wb;
        wa = RESULT_W'(a);
        wb = RESULT_W'(b);
        case (code)
            OP_ADD:  return wa + wb;
            OP_SUB:  return wa - wb;
            OP_AND:  return wa & wb;
            OP_XOR:  return wa ^ wb;
            OP_MUL:  return wa * wb;   // Full 32-bit product
            default: return 32'hdead_beef;
        endcase
    endfunction

    function automatic op_e opcode_class(input logic [3:0] code);
        case (code)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL: return op_e'(code);
            default:                                return OP_ILL;
        endcase
    endfunction

    task automatic build_table();
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            draw_operand(a);
            draw_operand(b);
            vec_mem[v]    = {OP_CODES[v], a, b};
            exp_result[v] = expected_result(OP_CODES[v], a, b);
        end
    endtask

    ////////////////////
    // UART receiver
    ////////////////////
    task automatic receive_byte(output logic [7:0] data);
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Mid start bit
        check_bit("tx start bit", tx, 1'b0);
        for (int i = 0; i < UART_DATA_BITS; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_bit("tx stop bit", tx, 1'b1);
    endtask

    // Frame counter, skips to the stop bit after each start edge
    always
    begin
        @(negedge tx);
        if (!rst)
            frame_cnt++;
        repeat (FRAME_CYCLES - CLKS_PER_BIT / 2) @(negedge clk);
    end

    initial
    begin
        #(WATCHDOG_NS);
        raise_error("Timeout: the test engine did not reach done in time");
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        logic [7:0]          rx;
        int                  seen_ops [16];
        int                  exp_ops [16];

        clk        = 1'b0;
        rst        = 1'b1;
        lfsr_state = 32'h7e72_962e;
        for (int i = 0; i < 16; i++)
        begin
            seen_ops[i] = 0;
            exp_ops[i]  = 0;
        end
        build_table();
        for (int v = 0; v < NUM_VECTORS; v++)
            exp_ops[4'(opcode_class(OP_CODES[v]))]++;

        repeat (RESET_CYCLES) @(negedge clk);
        check_bit("tx", tx, 1'b1);
        check_bit("done", done, 1'b0);
        check_addr(vec_addr, '0);
        rst = 1'b0;

        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            for (int b = 0; b < RESULT_BYTES; b++)
            begin
                receive_byte(rx);
                if (b == 0)
                begin
                    seen_ops[4'(DUT.u_decode.opcode)]++;
                    // Held op result, apart from the byte path
                    check_result($sformatf("vector %0d op result", v), DUT.u_op.result,
                                 exp_result[v]);
                end
                check_addr(vec_addr, ADDR_W'(v));   // Bytes arrive in address order
                check_byte($sformatf("vector %0d byte %0d", v, b), rx,
                           exp_result[v][8*b +: 8]);
            end
        end

        wait (done === 1'b1);
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            check_bit("done", done, 1'b1);
            check_bit("tx", tx, 1'b1);
        end

        if (frame_cnt != NUM_VECTORS * RESULT_BYTES)
            raise_error($sformatf("CHECK FAILED frame count: got 0x%h expected 0x%h",
                                  frame_cnt, NUM_VECTORS * RESULT_BYTES));
        foreach (OPS_COUNTED[i])
            check_opcode_count(OPS_COUNTED[i], seen_ops[4'(OPS_COUNTED[i])],
                               exp_ops[4'(OPS_COUNTED[i])]);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: sim.f
hw/hw_test_pkg.sv
hw/uart_pkg.sv
hw/test_sequencer.sv
hw/vector_decode.sv
hw/op_unit.sv
hw/result_serializer.sv
hw/uart_tx.sv
hw/hw_test_top.sv
dv/hw_test_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module hw_test_tb -f sim.f \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/Vhw_test_tb > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
